/* src.f */
logic/mem_fabric_pkg.sv
logic/addr_decoder.sv
logic/unified_ram.sv
logic/dm_apb_master.sv
logic/apb_arbiter.sv
logic/mem_fabric_top.sv
tb/apb_dm_model.sv
tb/tb_mem_fabric.sv

/* run.sh */
#!/bin/sh
# Build the fabric testbench with Verilator and run it.
# Exit status is 0 only when the pass message shows up in the output.
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f src.f --top-module tb_mem_fabric \
  && ./obj_dir/Vtb_mem_fabric | tee /dev/stderr | grep -F -q '*** TEST PASSED ***' \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

/* tb/tb_mem_fabric.sv */
// ==========================================================================
// Directed testbench of the memory fabric playing the hart's two ports.
// Runs RAM, debug module and tohost tests and prints a summary
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module tb_mem_fabric;

  import mem_fabric_pkg::*;

  logic            clk;
  logic            reset_n;
  logic            debug_mode;
  logic            imem_rready;
  logic [XLEN-1:0] imem_addr;
  logic            imem_rvalid;
  logic [XLEN-1:0] imem_rdata;
  logic [XLEN-1:0] dmem_addr;
  logic            dmem_wvalid;
  logic [XLEN-1:0] dmem_wdata;
  logic            dmem_rready;
  logic            dmem_wready;
  logic            dmem_rvalid;
  logic [XLEN-1:0] dmem_rdata;
  apb_req_t        apb_req;
  apb_rsp_t        apb_rsp;
  logic [XLEN-1:0] tohost;
  logic [1:0]      dm_wait;
  logic            load_en;
  logic [9:0]      load_idx;
  logic [XLEN-1:0] load_data;
  logic [31:0]     lfsr_state;
  int              checks;
  int              errors;
  int              errors_at_start;
  string           test_name;

  mem_fabric_top i_mem_fabric_top (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_debug_mode  (debug_mode),
    .i_imem_rready (imem_rready),
    .i_imem_addr   (imem_addr),
    .o_imem_rvalid (imem_rvalid),
    .o_imem_rdata  (imem_rdata),
    .i_dmem_addr   (dmem_addr),
    .i_dmem_wvalid (dmem_wvalid),
    .i_dmem_wdata  (dmem_wdata),
    .i_dmem_rready (dmem_rready),
    .o_dmem_wready (dmem_wready),
    .o_dmem_rvalid (dmem_rvalid),
    .o_dmem_rdata  (dmem_rdata),
    .o_apb_req     (apb_req),
    .i_apb_rsp     (apb_rsp),
    .o_tohost      (tohost)
  );

  apb_dm_model u_dm_model (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_req       (apb_req),
    .o_rsp       (apb_rsp),
    .i_wait      (dm_wait),
    .i_load      (load_en),
    .i_load_idx  (load_idx),
    .i_load_data (load_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================
  // Galois LFSR stepped once per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        out_bit;
    int          i;
    value = '0;
    for (i = 0; i < n; i++)
    begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit)
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      value = {value[30:0], out_bit};
    end
    return value;
  endfunction

  // Advance to the falling edge and pick a new wait count for the model
  task automatic next_cycle();
    logic [31:0] r;
    @(negedge clk);
    r       = rand_bits(2);
    dm_wait = r[1:0];
  endtask

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("error: test %s, %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    $display("test %s: %0d errors", test_name, errors - errors_at_start);
  endtask

  // Waits for every raised strobe to get its response and drops each strobe on it
  task automatic await_responses(input string what, output logic [XLEN-1:0] fdata,
                                 output logic [XLEN-1:0] ddata);
    logic            f_pend;
    logic            d_pend;
    logic            f_seen;
    logic            d_seen;
    logic [XLEN-1:0] f_samp;
    logic [XLEN-1:0] d_samp;
    int              cyc;
    f_pend = imem_rready;
    d_pend = dmem_rready || dmem_wvalid;
    fdata  = '0;
    ddata  = '0;
    cyc    = 0;
    while ((f_pend || d_pend) && (cyc < 200))
    begin
      next_cycle();
      cyc++;
      // Sample everything before any input moves
      f_seen = f_pend && imem_rvalid;
      d_seen = d_pend && (dmem_wvalid ? dmem_wready : dmem_rvalid);
      f_samp = imem_rdata;
      d_samp = dmem_rdata;
      if (f_seen)
      begin
        fdata       = f_samp;
        imem_rready = 1'b0;
        f_pend      = 1'b0;
      end
      if (d_seen)
      begin
        ddata       = d_samp;
        dmem_wvalid = 1'b0;
        dmem_rready = 1'b0;
        d_pend      = 1'b0;
      end
    end
    if (f_pend || d_pend)
    begin
      errors++;
      $display("timeout: %s in test %s got no response within 200 cycles", what, test_name);
      imem_rready = 1'b0;
      dmem_wvalid = 1'b0;
      dmem_rready = 1'b0;
    end
  endtask

  task automatic data_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata);
    logic [XLEN-1:0] f;
    logic [XLEN-1:0] d;
    dmem_addr   = addr;
    dmem_wdata  = wdata;
    dmem_wvalid = 1'b1;
    await_responses("data write", f, d);
  endtask

  task automatic data_read(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] data);
    logic [XLEN-1:0] f;
    dmem_addr   = addr;
    dmem_rready = 1'b1;
    await_responses("data read", f, data);
  endtask

  task automatic fetch(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] data);
    logic [XLEN-1:0] d;
    imem_addr   = addr;
    imem_rready = 1'b1;
    await_responses("fetch", data, d);
  endtask

  // Fetch and data read raised in the same cycle
  task automatic fetch_and_read(input logic [XLEN-1:0] faddr, input logic [XLEN-1:0] daddr,
                                output logic [XLEN-1:0] fdata, output logic [XLEN-1:0] ddata);
    imem_addr   = faddr;
    imem_rready = 1'b1;
    dmem_addr   = daddr;
    dmem_rready = 1'b1;
    await_responses("fetch with data read", fdata, ddata);
  endtask

  task automatic load_word(input logic [9:0] idx, input logic [XLEN-1:0] data);
    load_en   = 1'b1;
    load_idx  = idx;
    load_data = data;
    next_cycle();
    load_en   = 1'b0;
  endtask

  // ==========================================================================
  // Tests
  // ==========================================================================
  task automatic test_ram_alias();
    logic [XLEN-1:0] off;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;
    int              i;
    begin_test("ram_alias");
    for (i = 0; i < 4; i++)
    begin
      off   = rand_bits(12) << 2;
      wdata = rand_bits(32);
      data_write(RAM_BASE + off, wdata);
      data_read(RAM_BASE + off, rdata);
      check("direct read", wdata, rdata);
      // Top 18 bits set and the same low 14 bits
      data_read(32'hFFFF_C000 | off, rdata);
      check("alias read", wdata, rdata);
    end
    end_test();
  endtask

  task automatic test_fetch_vs_data();
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] stored [4];
    logic [XLEN-1:0] fdata;
    logic [XLEN-1:0] ddata;
    int              i;
    begin_test("fetch_vs_data");
    base = RAM_BASE + (rand_bits(10) << 4);
    for (i = 0; i < 4; i++)
    begin
      stored[i] = rand_bits(32);
      data_write(base + 4 * i, stored[i]);
    end
    // Data read wins the array and the fetch waits its turn
    for (i = 0; i < 4; i++)
    begin
      fetch_and_read(base + 4 * i, base + 4 * (3 - i), fdata, ddata);
      check("fetch", stored[i], fdata);
      check("data read", stored[3 - i], ddata);
    end
    end_test();
  endtask

  task automatic test_debug_write();
    logic [31:0]     r;
    logic [9:0]      idx;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;
    int              i;
    begin_test("debug_write");
    debug_mode = 1'b1;
    for (i = 0; i < 3; i++)
    begin
      r     = rand_bits(9);
      idx   = 10'h080 + {1'b0, r[8:0]};
      addr  = {20'h0, idx, 2'b00};
      wdata = rand_bits(32);
      data_write(addr, wdata);
      data_read(addr, rdata);
      check("read back", wdata, rdata);
      check("model word", wdata, u_dm_model.words[idx]);
    end
    end_test();
  endtask

  task automatic test_debug_fetch();
    logic [XLEN-1:0] words [9];
    logic [XLEN-1:0] dword;
    logic [XLEN-1:0] fdata;
    logic [XLEN-1:0] ddata;
    logic [31:0]     r;
    logic [9:0]      idx;
    logic [9:0]      didx;
    int              i;
    begin_test("debug_fetch");
    for (i = 0; i < 9; i++)
    begin
      words[i] = rand_bits(32);
      idx      = 10'h080 + 10'(i);
      load_word(idx, words[i]);
    end
    r     = rand_bits(7);
    didx  = 10'h100 + {3'b0, r[6:0]};
    dword = rand_bits(32);
    load_word(didx, dword);
    // Fetches from 0x200 upward
    for (i = 0; i < 8; i++)
    begin
      idx = 10'h080 + 10'(i);
      fetch({20'h0, idx, 2'b00}, fdata);
      check("fetch", words[i], fdata);
    end
    // Both masters at once through the arbiter
    idx = 10'h088;
    fetch_and_read({20'h0, idx, 2'b00}, {20'h0, didx, 2'b00}, fdata, ddata);
    check("arbitrated fetch", words[8], fdata);
    check("arbitrated data read", dword, ddata);
    end_test();
  endtask

  task automatic test_debug_error();
    logic [XLEN-1:0] kept;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] fdata;
    begin_test("debug_error");
    kept = rand_bits(32);
    load_word(10'h3FF, kept);
    // Each one must finish despite the error
    data_write(32'h0000_0FFC, ~kept);
    // The refused write leaves the stored word for both read paths
    data_read(32'h0000_0FFC, rdata);
    check("data read after failed write", kept, rdata);
    fetch(32'h0000_0FFC, fdata);
    check("fetch after failed write", kept, fdata);
    end_test();
  endtask

  task automatic test_tohost();
    logic [XLEN-1:0] kept;
    logic [XLEN-1:0] value;
    logic [XLEN-1:0] rdata;
    begin_test("tohost");
    debug_mode = 1'b0;
    // RAM word that a sloppy decode of the tohost address would hit
    kept = rand_bits(32);
    data_write(RAM_BASE + 32'h1000, kept);
    value = rand_bits(32);
    data_write(TOHOST_ADDR, value);
    check("tohost", value, tohost);
    data_read(RAM_BASE + 32'h1000, rdata);
    check("ram word", kept, rdata);
    end_test();
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial
  begin
    lfsr_state  = 32'd87924;
    checks      = 0;
    errors      = 0;
    reset_n     = 1'b0;
    debug_mode  = 1'b0;
    imem_rready = 1'b0;
    imem_addr   = RAM_BASE;
    dmem_addr   = RAM_BASE;
    dmem_wvalid = 1'b0;
    dmem_wdata  = '0;
    dmem_rready = 1'b0;
    dm_wait     = 2'd0;
    load_en     = 1'b0;
    load_idx    = '0;
    load_data   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    next_cycle();
    test_ram_alias();
    test_fetch_vs_data();
    test_debug_write();
    test_debug_fetch();
    test_debug_error();
    test_tohost();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/apb_dm_model.sv */
// ==========================================================================
// Debug module APB slave model for the fabric testbench.
// Word storage, 0 to 3 wait cycles per transfer, error response at 0xFFC
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module apb_dm_model (
  input  wire logic                            clk,
  input  wire logic                            reset_n,
  input  wire mem_fabric_pkg::apb_req_t        i_req,
  output mem_fabric_pkg::apb_rsp_t             o_rsp,
  // Wait count for the next transfer
  input  wire logic [1:0]                      i_wait,
  // Backdoor preload of one word
  input  wire logic                            i_load,
  input  wire logic [9:0]                      i_load_idx,
  input  wire logic [mem_fabric_pkg::XLEN-1:0] i_load_data
);

  import mem_fabric_pkg::*;

  logic [XLEN-1:0] words [1024];
  logic [1:0]      wait_next;
  logic [1:0]      cnt;
  logic            busy;
  logic            access;
  logic            last;
  logic            err;

  assign access = i_req.psel && i_req.penable;
  // First ACCESS cycle uses the sampled count, later ones the countdown
  assign last   = access && (busy ? (cnt == 2'd0) : (wait_next == 2'd0));
  // Top word of the window always answers with an error
  assign err    = (i_req.paddr == 13'h0FFC);

  always_comb
  begin
    o_rsp.pready  = last;
    o_rsp.pslverr = last && err;
    o_rsp.prdata  = words[i_req.paddr[11:2]];
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      busy      <= 1'b0;
      cnt       <= 2'd0;
      wait_next <= 2'd0;
    end
    else
    begin
      wait_next <= i_wait;
      if (!access || last)
        busy <= 1'b0;
      else if (!busy)
      begin
        busy <= 1'b1;
        cnt  <= wait_next - 2'd1;
      end
      else
        cnt <= cnt - 2'd1;
    end
  end

  // Failed writes leave the array alone
  always_ff @(posedge clk)
  begin
    if (i_load)
      words[i_load_idx] <= i_load_data;
    else if (last && i_req.pwrite && !err)
      words[i_req.paddr[11:2]] <= i_req.pwdata;
  end

endmodule

`default_nettype wire

/* logic/mem_fabric_top.sv */
// ========================================================================
// Memory fabric between a hart's fetch and data ports and its memories.
// RAM, debug module over APB and the tohost register
// ========================================================================
`timescale 1ns/100ps
`default_nettype none

module mem_fabric_top (
  input  wire logic                              clk,
  input  wire logic                              reset_n,
  input  wire logic                              i_debug_mode,
  // Fetch port
  input  wire logic                              i_imem_rready,
  input  wire logic [mem_fabric_pkg::XLEN-1:0]   i_imem_addr,
  output logic                                   o_imem_rvalid,
  output logic [mem_fabric_pkg::XLEN-1:0]        o_imem_rdata,
  // Data port
  input  wire logic [mem_fabric_pkg::XLEN-1:0]   i_dmem_addr,
  input  wire logic                              i_dmem_wvalid,
  input  wire logic [mem_fabric_pkg::XLEN-1:0]   i_dmem_wdata,
  input  wire logic                              i_dmem_rready,
  output logic                                   o_dmem_wready,
  output logic                                   o_dmem_rvalid,
  output logic [mem_fabric_pkg::XLEN-1:0]        o_dmem_rdata,
  // Debug module APB
  output mem_fabric_pkg::apb_req_t               o_apb_req,
  input  wire mem_fabric_pkg::apb_rsp_t          i_apb_rsp,
  output logic [mem_fabric_pkg::XLEN-1:0]        o_tohost
);

  import mem_fabric_pkg::*;

  region_t               imem_region;
  region_t               dmem_region;
  logic [RAM_ADDR_W-1:0] imem_word;
  logic [RAM_ADDR_W-1:0] dmem_word;
  logic                  ram_fetch_rd;
  logic                  ram_data_rd;
  logic                  ram_data_wr;
  logic                  ram_fetch_rvalid;
  logic [XLEN-1:0]       ram_fetch_rdata;
  logic                  ram_data_rvalid;
  logic [XLEN-1:0]       ram_data_rdata;
  logic                  dbg_fetch_start;
  logic                  dbg_data_start;
  logic                  tohost_wr;
  dm_fetch_t             fetch_req;
  dm_access_t            data_req;
  apb_req_t              fetch_apb;
  apb_req_t              data_apb;
  apb_rsp_t              fetch_rsp;
  apb_rsp_t              data_rsp;
  logic                  fetch_done;
  logic                  data_done;
  logic [XLEN-1:0]       fetch_apb_rdata;
  logic [XLEN-1:0]       data_apb_rdata;

  addr_decoder u_addr_decoder (
    .i_debug_mode  (i_debug_mode),
    .i_imem_addr   (i_imem_addr),
    .i_dmem_addr   (i_dmem_addr),
    .o_imem_region (imem_region),
    .o_dmem_region (dmem_region),
    .o_imem_word   (imem_word),
    .o_dmem_word   (dmem_word)
  );

  // ========================================================================
  // Strobe steering by region
  // ========================================================================
  assign ram_fetch_rd    = i_imem_rready && (imem_region == REGION_RAM);
  assign ram_data_rd     = i_dmem_rready && (dmem_region == REGION_RAM);
  assign ram_data_wr     = i_dmem_wvalid && (dmem_region == REGION_RAM);
  assign dbg_fetch_start = i_imem_rready && (imem_region == REGION_DEBUG);
  assign dbg_data_start  = (i_dmem_wvalid || i_dmem_rready) && (dmem_region == REGION_DEBUG);
  assign tohost_wr       = i_dmem_wvalid && (dmem_region == REGION_TOHOST);

  assign fetch_req = '{addr: i_imem_addr};
  assign data_req  = '{addr: i_dmem_addr, write: i_dmem_wvalid, wdata: i_dmem_wdata};

  unified_ram u_unified_ram (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_fetch_rd     (ram_fetch_rd),
    .i_fetch_word   (imem_word),
    .i_data_rd      (ram_data_rd),
    .i_data_wr      (ram_data_wr),
    .i_data_word    (dmem_word),
    .i_data_wdata   (i_dmem_wdata),
    .o_fetch_rvalid (ram_fetch_rvalid),
    .o_fetch_rdata  (ram_fetch_rdata),
    .o_data_rvalid  (ram_data_rvalid),
    .o_data_rdata   (ram_data_rdata)
  );

  // Fetches never write
  dm_apb_master #(
    .req_t    (dm_fetch_t),
    .WRITABLE (1'b0)
  ) u_fetch_master (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_debug_mode (i_debug_mode),
    .i_start      (dbg_fetch_start),
    .i_req        (fetch_req),
    .o_apb        (fetch_apb),
    .i_apb        (fetch_rsp),
    .o_done       (fetch_done),
    .o_rdata      (fetch_apb_rdata)
  );

  dm_apb_master #(
    .req_t    (dm_access_t),
    .WRITABLE (1'b1)
  ) u_data_master (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_debug_mode (i_debug_mode),
    .i_start      (dbg_data_start),
    .i_req        (data_req),
    .o_apb        (data_apb),
    .i_apb        (data_rsp),
    .o_done       (data_done),
    .o_rdata      (data_apb_rdata)
  );

  apb_arbiter u_apb_arbiter (
    .clk     (clk),
    .reset_n (reset_n),
    .i_m0    (fetch_apb),
    .i_m1    (data_apb),
    .o_m0    (fetch_rsp),
    .o_m1    (data_rsp),
    .o_slave (o_apb_req),
    .i_slave (i_apb_rsp)
  );

  // ========================================================================
  // Responses toward the hart
  // ========================================================================
  assign o_imem_rvalid = ram_fetch_rvalid || fetch_done;
  assign o_imem_rdata  = fetch_done ? fetch_apb_rdata : ram_fetch_rdata;

  // Latched pwrite tells a debug write completion from a read
  assign o_dmem_rvalid = ram_data_rvalid || (data_done && !data_apb.pwrite);
  assign o_dmem_rdata  = data_done ? data_apb_rdata : ram_data_rdata;
  assign o_dmem_wready = ram_data_wr || tohost_wr || (data_done && data_apb.pwrite);

  // Tohost register
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      o_tohost <= '0;
    else if (tohost_wr)
      o_tohost <= i_dmem_wdata;
  end

endmodule

`default_nettype wire

/* logic/apb_arbiter.sv */
// ========================================================================
// Two-master APB arbiter onto the debug module port, master 0 first
// ========================================================================
`timescale 1ns/100ps
`default_nettype none

module apb_arbiter (
  input  wire logic                      clk,
  input  wire logic                      reset_n,
  input  wire mem_fabric_pkg::apb_req_t  i_m0,
  input  wire mem_fabric_pkg::apb_req_t  i_m1,
  output mem_fabric_pkg::apb_rsp_t       o_m0,
  output mem_fabric_pkg::apb_rsp_t       o_m1,
  output mem_fabric_pkg::apb_req_t       o_slave,
  input  wire mem_fabric_pkg::apb_rsp_t  i_slave
);

  import mem_fabric_pkg::*;

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_M0,
    GNT_M1
  } gnt_t;

  gnt_t gnt_q;
  gnt_t gnt;
  logic slave_done;

  // Held grant, else pick a new one in the SETUP cycle
  always_comb
  begin
    gnt = gnt_q;
    if (gnt_q == GNT_NONE)
    begin
      if (i_m0.psel)
        gnt = GNT_M0;
      else if (i_m1.psel)
        gnt = GNT_M1;
    end
  end

  always_comb
  begin
    case (gnt)
      GNT_M0:  o_slave = i_m0;
      GNT_M1:  o_slave = i_m1;
      default: o_slave = '0;
    endcase
  end

  assign slave_done = o_slave.penable && (i_slave.pready || i_slave.pslverr);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      gnt_q <= GNT_NONE;
    else if (slave_done)
      gnt_q <= GNT_NONE;
    else
      gnt_q <= gnt;
  end

  // ========================================================================
  // Response routing
  // ========================================================================
  // Read data is shared, the handshake bits go to the owner only
  always_comb
  begin
    o_m0         = i_slave;
    o_m1         = i_slave;
    o_m0.pready  = i_slave.pready && (gnt == GNT_M0);
    o_m0.pslverr = i_slave.pslverr && (gnt == GNT_M0);
    o_m1.pready  = i_slave.pready && (gnt == GNT_M1);
    o_m1.pslverr = i_slave.pslverr && (gnt == GNT_M1);
  end

  a_grant_stable: assert property (@(posedge clk) disable iff (!reset_n)
    (o_slave.penable && !slave_done) |=> (gnt == $past(gnt)));

endmodule

`default_nettype wire

/* logic/dm_apb_master.sv */
// ========================================================================
// APB master for debug-area accesses, IDLE then SETUP then ACCESS.
// Set WRITABLE when the payload carries write and wdata fields
// ========================================================================
`timescale 1ns/100ps
`default_nettype none

module dm_apb_master #(
  parameter type req_t    = mem_fabric_pkg::dm_access_t,
  parameter bit  WRITABLE = 1'b1
) (
  input  wire logic                            clk,
  input  wire logic                            reset_n,
  input  wire logic                            i_debug_mode,
  input  wire logic                            i_start,
  input  wire req_t                            i_req,
  output mem_fabric_pkg::apb_req_t             o_apb,
  input  wire mem_fabric_pkg::apb_rsp_t        i_apb,
  output logic                                 o_done,
  output logic [mem_fabric_pkg::XLEN-1:0]      o_rdata
);

  import mem_fabric_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_t;

  state_t          state_q;
  state_t          state_d;
  req_t            req_q;
  logic            req_write;
  logic [XLEN-1:0] req_wdata;

  // ========================================================================
  // FSM
  // ========================================================================
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (i_start)
          state_d = ST_SETUP;
      ST_SETUP:
        state_d = ST_ACCESS;
      ST_ACCESS:
        // Error ends the transfer just like ready
        if (i_apb.pready || i_apb.pslverr)
          state_d = ST_IDLE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      state_q <= ST_IDLE;
    else if (!i_debug_mode)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // Request captured once and held for the whole transfer
  always_ff @(posedge clk)
  begin
    if ((state_q == ST_IDLE) && i_start)
      req_q <= i_req;
  end

  if (WRITABLE)
  begin : g_write
    assign req_write = req_q.write;
    assign req_wdata = req_q.wdata;
  end
  else
  begin : g_read_only
    assign req_write = 1'b0;
    assign req_wdata = '0;
  end

  // ========================================================================
  // Bus outputs
  // ========================================================================
  always_comb
  begin
    o_apb.paddr   = req_q.addr[APB_ADDR_W-1:0];
    o_apb.psel    = (state_q != ST_IDLE);
    o_apb.penable = (state_q == ST_ACCESS);
    o_apb.pwrite  = req_write;
    o_apb.pwdata  = req_wdata;
  end

  assign o_done  = (state_q == ST_ACCESS) && (i_apb.pready || i_apb.pslverr);
  assign o_rdata = i_apb.prdata;

  // Every ACCESS phase follows a SETUP cycle
  a_setup_first: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(o_apb.penable) |-> (o_apb.psel && $past(o_apb.psel)));

endmodule

`default_nettype wire

/* logic/unified_ram.sv */
// ========================================================================
// Single-port program RAM shared by fetch and data with the data side first.
// Reads return two edges after the grant with a one-cycle valid
// ========================================================================
`timescale 1ns/100ps
`default_nettype none

module unified_ram (
  input  wire logic                                clk,
  input  wire logic                                reset_n,
  input  wire logic                                i_fetch_rd,
  input  wire logic [mem_fabric_pkg::RAM_ADDR_W-1:0] i_fetch_word,
  input  wire logic                                i_data_rd,
  input  wire logic                                i_data_wr,
  input  wire logic [mem_fabric_pkg::RAM_ADDR_W-1:0] i_data_word,
  input  wire logic [mem_fabric_pkg::XLEN-1:0]     i_data_wdata,
  output logic                                     o_fetch_rvalid,
  output logic [mem_fabric_pkg::XLEN-1:0]          o_fetch_rdata,
  output logic                                     o_data_rvalid,
  output logic [mem_fabric_pkg::XLEN-1:0]          o_data_rdata
);

  import mem_fabric_pkg::*;

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_WR,
    GNT_DRD,
    GNT_FRD
  } gnt_t;

  logic [XLEN-1:0]       mem [RAM_DEPTH];
  gnt_t                  gnt;
  gnt_t                  gnt_q;
  gnt_t                  gnt_q2;
  logic [RAM_ADDR_W-1:0] ram_addr;
  logic [XLEN-1:0]       rd_q;
  logic [XLEN-1:0]       ret_q;
  logic [XLEN-1:0]       out_q;
  // One read in flight per port
  logic                  fetch_busy;
  logic                  data_busy;

  // ========================================================================
  // Arbitration order is write, then data read, then fetch
  // ========================================================================
  always_comb
  begin
    gnt      = GNT_NONE;
    ram_addr = i_fetch_word;
    if (i_data_wr)
    begin
      gnt      = GNT_WR;
      ram_addr = i_data_word;
    end
    else if (i_data_rd && !data_busy)
    begin
      gnt      = GNT_DRD;
      ram_addr = i_data_word;
    end
    else if (i_fetch_rd && !fetch_busy)
      gnt = GNT_FRD;
  end

  // Array and read data pipe
  always_ff @(posedge clk)
  begin
    if (gnt == GNT_WR)
      mem[ram_addr] <= i_data_wdata;
    else if (gnt != GNT_NONE)
      rd_q <= mem[ram_addr];
    ret_q <= rd_q;
    out_q <= ret_q;
  end

  // ========================================================================
  // Grant pipe and return valids
  // ========================================================================
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      gnt_q          <= GNT_NONE;
      gnt_q2         <= GNT_NONE;
      o_fetch_rvalid <= 1'b0;
      o_data_rvalid  <= 1'b0;
      fetch_busy     <= 1'b0;
      data_busy      <= 1'b0;
    end
    else
    begin
      gnt_q          <= gnt;
      gnt_q2         <= gnt_q;
      o_fetch_rvalid <= (gnt_q2 == GNT_FRD);
      o_data_rvalid  <= (gnt_q2 == GNT_DRD);
      // Busy until the return or until the requester gives up
      if (gnt == GNT_FRD)
        fetch_busy <= 1'b1;
      else if (o_fetch_rvalid || !i_fetch_rd)
        fetch_busy <= 1'b0;
      if (gnt == GNT_DRD)
        data_busy <= 1'b1;
      else if (o_data_rvalid || !i_data_rd)
        data_busy <= 1'b0;
    end
  end

  // Both ports see the same return register and the valid tells whose it is
  assign o_fetch_rdata = out_q;
  assign o_data_rdata  = out_q;

  // One read in flight per port means no port sees back-to-back returns
  a_one_in_flight: assert property (@(posedge clk) disable iff (!reset_n)
    !(o_fetch_rvalid && $past(o_fetch_rvalid)) &&
    !(o_data_rvalid && $past(o_data_rvalid)));

endmodule

`default_nettype wire

/* logic/addr_decoder.sv */
// ========================================================================
// Region decode of the fetch and data addresses, plus RAM word addresses
// ========================================================================
`timescale 1ns/100ps
`default_nettype none

module addr_decoder (
  input  wire logic                                i_debug_mode,
  input  wire logic [mem_fabric_pkg::XLEN-1:0]     i_imem_addr,
  input  wire logic [mem_fabric_pkg::XLEN-1:0]     i_dmem_addr,
  output mem_fabric_pkg::region_t                  o_imem_region,
  output mem_fabric_pkg::region_t                  o_dmem_region,
  output logic [mem_fabric_pkg::RAM_ADDR_W-1:0]    o_imem_word,
  output logic [mem_fabric_pkg::RAM_ADDR_W-1:0]    o_dmem_word
);

  import mem_fabric_pkg::*;

  // Top 18 bits all ones folds onto program RAM
  function automatic logic is_alias(input logic [XLEN-1:0] addr);
    return (addr[XLEN-1:14] == '1);
  endfunction

  // Debug window wins over RAM, and only in debug mode
  function automatic region_t classify(input logic [XLEN-1:0] addr, input logic dbg);
    if (dbg && (addr >= DEBUG_AREA_START) && (addr <= DEBUG_AREA_END))
      return REGION_DEBUG;
    if (((addr >= RAM_BASE) && (addr <= RAM_END)) || is_alias(addr))
      return REGION_RAM;
    if (addr == TOHOST_ADDR)
      return REGION_TOHOST;
    return REGION_NONE;
  endfunction

  // Byte offset into RAM, then drop the byte lane bits
  function automatic logic [RAM_ADDR_W-1:0] word_of(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] offs;
    offs = is_alias(addr) ? {18'h0, addr[13:0]} : (addr - RAM_BASE);
    return offs[RAM_ADDR_W+1:2];
  endfunction

  always_comb
  begin
    o_imem_region = classify(i_imem_addr, i_debug_mode);
    o_dmem_region = classify(i_dmem_addr, i_debug_mode);
    o_imem_word   = word_of(i_imem_addr);
    o_dmem_word   = word_of(i_dmem_addr);
  end

endmodule

`default_nettype wire

/* logic/mem_fabric_pkg.sv */
// ========================================================================
// Address map, bus widths and shared types of the hart memory fabric
// ========================================================================
`default_nettype none

package mem_fabric_pkg;

  // ========================================================================
  // Widths
  // ========================================================================
  localparam int XLEN       = 32;
  localparam int APB_ADDR_W = 13;
  localparam int RAM_DEPTH  = 4096;
  localparam int RAM_ADDR_W = 12;

  // ========================================================================
  // Address map
  // ========================================================================
  // Program RAM, 16 KB
  localparam logic [XLEN-1:0] RAM_BASE         = 32'h0001_0000;
  localparam logic [XLEN-1:0] RAM_END          = 32'h0001_3FFF;
  // Debug module window, only decoded in debug mode
  localparam logic [XLEN-1:0] DEBUG_AREA_START = 32'h0000_0200;
  localparam logic [XLEN-1:0] DEBUG_AREA_END   = 32'h0000_0FFF;
  // Test completion register
  localparam logic [XLEN-1:0] TOHOST_ADDR      = 32'h8000_1000;

  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_DEBUG,
    REGION_TOHOST,
    REGION_NONE
  } region_t;

  // Master to slave half of APB
  typedef struct packed {
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [XLEN-1:0]       pwdata;
  } apb_req_t;

  // Slave to master half of APB
  typedef struct packed {
    logic            pready;
    logic [XLEN-1:0] prdata;
    logic            pslverr;
  } apb_rsp_t;

  // Debug-area fetch, read only
  typedef struct packed {
    logic [XLEN-1:0] addr;
  } dm_fetch_t;

  // Debug-area data access
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            write;
    logic [XLEN-1:0] wdata;
  } dm_access_t;

endpackage

`default_nettype wire
